//--- include/adc_ctrl_config.svh
`ifndef ADC_CTRL_CONFIG_SVH
`define ADC_CTRL_CONFIG_SVH

// OPB address window of the controller. Both ends are inclusive.
`define ADC_CTRL_BASEADDR 32'h0000_0000
`define ADC_CTRL_HIGHADDR 32'h0000_FFFF

// serial clock divider width, so one serial bit lasts 2**width bus clocks.
`define ADC_CFG_DIV_BITS 4

// number of bits in one three-wire programming frame.
`define ADC_CFG_FRAME_BITS 32

// the DCM reset is stretched by this many bus clocks after an ADC reset.
`define ADC_DCM_RESET_CYCLES 255

`endif

//--- source/adc_ctrl_pkg.sv
`default_nettype none

`include "adc_ctrl_config.svh"

package adc_ctrl_pkg;

  // bus word in OPB bit order, bit 0 is the most significant bit.
  typedef logic [0:31] opb_word_t;

  // register selector, taken from address bits 3:2.
  typedef enum logic [1:0] {
    REG_CTRL = 2'd0,
    REG_CFG0 = 2'd1,
    REG_CFG1 = 2'd2,
    REG_RSVD = 2'd3
  } opb_reg_e;

  typedef logic [3:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // prefix, address and data, most significant bit sent first.
  typedef logic [`ADC_CFG_FRAME_BITS-1:0] cfg_frame_t;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_CLKWAIT,
    CFG_DATA,
    CFG_FINISH
  } cfg_state_e;

endpackage

`default_nettype wire

//--- source/adc_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

// one ADC's programming request from the register bank to its serial engine.
interface adc_cfg_if
  import adc_ctrl_pkg::*;
();

  cfg_addr_t cfg_addr;
  cfg_data_t cfg_data;
  logic      cfg_start;
  logic      cfg_done;

  modport bank (
    output cfg_addr,
    output cfg_data,
    output cfg_start,
    input  cfg_done
  );

  modport engine (
    input  cfg_addr,
    input  cfg_data,
    input  cfg_start,
    output cfg_done
  );

endinterface

`default_nettype wire

//--- source/opb_reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_config.svh"

module opb_reg_bank
  import adc_ctrl_pkg::*;
(
  input  logic       OPB_Clk,
  input  logic       arst_n,
  input  opb_word_t  opb_abus,
  input  logic [0:3] opb_be,
  input  opb_word_t  opb_dbus,
  input  logic       opb_rnw,
  input  logic       opb_select,
  input  logic       adc0_psdone,
  input  logic       adc1_psdone,
  output opb_word_t  sl_dbus,
  output logic       sl_xfer_ack,
  output logic       adc0_reset_pulse,
  output logic       adc1_reset_pulse,
  output logic       hold_resets,
  output logic       adc0_psen,
  output logic       adc0_psincdec,
  output logic       adc1_psen,
  output logic       adc1_psincdec,
  adc_cfg_if.bank    cfg0,
  adc_cfg_if.bank    cfg1
);

  localparam opb_reg_e CFG_REG [2] = '{REG_CFG0, REG_CFG1};

  logic [31:0] addr_offset;
  logic        in_window;
  logic        xfer_req;
  logic        wr_en;
  logic        ack_q;
  opb_reg_e    reg_sel;
  logic        cfg_idx;
  cfg_addr_t   cfg_addr_q [2];
  cfg_data_t   cfg_data_q [2];
  logic [1:0]  cfg_start_q;
  logic [1:0]  cfg_done;
  opb_word_t   rd_data;

  ////////////////////////////////////////////////////////////
  // address decode and acknowledge
  ////////////////////////////////////////////////////////////

  assign in_window   = (opb_abus >= `ADC_CTRL_BASEADDR) && (opb_abus <= `ADC_CTRL_HIGHADDR);
  assign addr_offset = opb_abus - `ADC_CTRL_BASEADDR;
  assign reg_sel     = opb_reg_e'(addr_offset[3:2]);

  // a held select is acknowledged on every other cycle.
  assign xfer_req = opb_select && in_window && !ack_q;
  assign wr_en    = xfer_req && !opb_rnw;

  ////////////////////////////////////////////////////////////
  // register writes and strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q            <= 1'b0;
      adc0_reset_pulse <= 1'b0;
      adc1_reset_pulse <= 1'b0;
      hold_resets      <= 1'b1;
      adc0_psen        <= 1'b0;
      adc0_psincdec    <= 1'b0;
      adc1_psen        <= 1'b0;
      adc1_psincdec    <= 1'b0;
      cfg_start_q      <= '0;
      for (int i = 0; i < 2; i++) begin
        cfg_addr_q[i] <= '0;
        cfg_data_q[i] <= '0;
      end
    end else begin
      ack_q            <= xfer_req;
      adc0_reset_pulse <= 1'b0;
      adc1_reset_pulse <= 1'b0;
      adc0_psen        <= 1'b0;
      adc1_psen        <= 1'b0;
      cfg_start_q      <= '0;

      if (wr_en && reg_sel == REG_CTRL) begin
        // the DCMs stay in reset until software first touches this byte.
        if (opb_be[3]) begin
          adc0_reset_pulse <= opb_dbus[31];
          adc1_reset_pulse <= opb_dbus[30];
          hold_resets      <= 1'b0;
        end
        if (opb_be[1]) begin
          adc0_psen     <= opb_dbus[15];
          adc0_psincdec <= opb_dbus[14];
          adc1_psen     <= opb_dbus[11];
          adc1_psincdec <= opb_dbus[10];
        end
      end

      for (int i = 0; i < 2; i++) begin
        if (wr_en && reg_sel == CFG_REG[i]) begin
          if (opb_be[0]) begin
            cfg_data_q[i][15:8] <= opb_dbus[0:7];
          end
          if (opb_be[1]) begin
            cfg_data_q[i][7:0] <= opb_dbus[8:15];
          end
          if (opb_be[2]) begin
            cfg_addr_q[i] <= opb_dbus[20:23];
          end
          if (opb_be[3]) begin
            cfg_start_q[i] <= opb_dbus[31];
          end
        end
      end
    end
  end

  assign cfg0.cfg_addr  = cfg_addr_q[0];
  assign cfg0.cfg_data  = cfg_data_q[0];
  assign cfg0.cfg_start = cfg_start_q[0];
  assign cfg1.cfg_addr  = cfg_addr_q[1];
  assign cfg1.cfg_data  = cfg_data_q[1];
  assign cfg1.cfg_start = cfg_start_q[1];
  assign cfg_done       = {cfg1.cfg_done, cfg0.cfg_done};

  ////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////

  assign cfg_idx = (reg_sel == REG_CFG1);

  always_comb begin
    rd_data = '0;
    unique case (reg_sel)
      REG_CTRL: begin
        rd_data[2]  = adc1_psdone;
        rd_data[3]  = adc0_psdone;
        rd_data[10] = adc1_psincdec;
        rd_data[11] = adc1_psen;
        rd_data[14] = adc0_psincdec;
        rd_data[15] = adc0_psen;
      end
      REG_CFG0, REG_CFG1: begin
        rd_data[0:15]  = cfg_data_q[cfg_idx];
        rd_data[20:23] = cfg_addr_q[cfg_idx];
        rd_data[31]    = cfg_done[cfg_idx];
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  assign sl_dbus     = ack_q ? rd_data : '0;
  assign sl_xfer_ack = ack_q;

endmodule

`default_nettype wire

//--- source/adc_serial_cfg.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_config.svh"

module adc_serial_cfg
  import adc_ctrl_pkg::*;
(
  input  logic      OPB_Clk,
  input  logic      arst_n,
  adc_cfg_if.engine cfg,
  output logic      ser_clk,
  output logic      ser_data,
  output logic      ser_strobe_n
);

  localparam int DIV_BITS   = `ADC_CFG_DIV_BITS;
  localparam int FRAME_BITS = `ADC_CFG_FRAME_BITS;
  localparam int CNT_BITS   = $clog2(FRAME_BITS);

  // the ADC expects this fixed prefix ahead of address and data.
  localparam logic [11:0] FRAME_PREFIX = 12'h001;

  cfg_state_e          state;
  logic [DIV_BITS-1:0] div_cnt;
  logic                div_wrap;
  logic [CNT_BITS-1:0] bit_cnt;
  cfg_frame_t          shift_q;
  logic                start_ok;

  assign start_ok = (state == CFG_IDLE) && cfg.cfg_start;

  ////////////////////////////////////////////////////////////
  // bit period divider
  ////////////////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
    end else if (state == CFG_IDLE) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign div_wrap = &div_cnt;

  ////////////////////////////////////////////////////////////
  // frame sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= CFG_IDLE;
      bit_cnt <= '0;
    end else begin
      unique case (state)
        CFG_IDLE: begin
          if (cfg.cfg_start) begin
            state <= CFG_CLKWAIT;
          end
        end
        CFG_CLKWAIT: begin
          if (div_wrap) begin
            state   <= CFG_DATA;
            bit_cnt <= '0;
          end
        end
        CFG_DATA: begin
          if (div_wrap) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_BITS'(FRAME_BITS - 1)) begin
              state <= CFG_FINISH;
            end
          end
        end
        CFG_FINISH: begin
          if (div_wrap) begin
            state <= CFG_IDLE;
          end
        end
        default: begin
          state <= CFG_IDLE;
        end
      endcase
    end
  end

  // bits move on the divider wrap, half a period before the clock rises.
  always_ff @(posedge OPB_Clk) begin
    if (start_ok) begin
      shift_q <= {FRAME_PREFIX, cfg.cfg_addr, cfg.cfg_data};
    end else if (state == CFG_DATA && div_wrap) begin
      shift_q <= shift_q << 1;
    end
  end

  assign ser_clk      = div_cnt[DIV_BITS-1];
  assign ser_data     = shift_q[FRAME_BITS-1];
  assign ser_strobe_n = (state != CFG_DATA);
  assign cfg.cfg_done = (state == CFG_IDLE);

endmodule

`default_nettype wire

//--- source/adc_dcm_reset_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_config.svh"

module adc_dcm_reset_gen (
  input  logic OPB_Clk,
  input  logic arst_n,
  input  logic reset_pulse,
  input  logic hold_resets,
  output logic adc_reset,
  output logic dcm_reset
);

  localparam int CNT_BITS = $clog2(`ADC_DCM_RESET_CYCLES + 1);
  localparam logic [CNT_BITS-1:0] STRETCH = CNT_BITS'(`ADC_DCM_RESET_CYCLES);

  logic [CNT_BITS-1:0] stretch_cnt;

  // adc_reset is meant to be packed into the output pad register.
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_reset   <= 1'b1;
      stretch_cnt <= STRETCH;
    end else begin
      adc_reset <= reset_pulse;
      if (reset_pulse) begin
        stretch_cnt <= STRETCH;
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
    end
  end

  // the DCM may only relock once the ADC clock has settled again.
  assign dcm_reset = hold_resets || (stretch_cnt != '0);

endmodule

`default_nettype wire

//--- source/opb_adc_controller.sv
`timescale 1ns/10ps
`default_nettype none

module opb_adc_controller
  import adc_ctrl_pkg::*;
(
  input  logic       OPB_Clk,
  input  logic       arst_n,
  input  opb_word_t  OPB_ABus,
  input  logic [0:3] OPB_BE,
  input  opb_word_t  OPB_DBus,
  input  logic       OPB_RNW,
  input  logic       OPB_select,
  output opb_word_t  Sl_DBus,
  output logic       Sl_xferAck,
  output logic       Sl_errAck,
  output logic       Sl_retry,
  output logic       Sl_toutSup,

  output logic       adc0_adc3wire_clk,
  output logic       adc0_adc3wire_data,
  output logic       adc0_adc3wire_strobe,
  output logic       adc0_adc_reset,
  output logic       adc0_dcm_reset,
  output logic       adc0_psclk,
  output logic       adc0_psen,
  output logic       adc0_psincdec,
  input  logic       adc0_psdone,

  output logic       adc1_adc3wire_clk,
  output logic       adc1_adc3wire_data,
  output logic       adc1_adc3wire_strobe,
  output logic       adc1_adc_reset,
  output logic       adc1_dcm_reset,
  output logic       adc1_psclk,
  output logic       adc1_psen,
  output logic       adc1_psincdec,
  input  logic       adc1_psdone
);

  logic adc0_reset_pulse;
  logic adc1_reset_pulse;
  logic hold_resets;

  adc_cfg_if cfg0_if ();
  adc_cfg_if cfg1_if ();

  // this slave never signals errors, retries or timeout suppression.
  assign Sl_errAck  = 1'b0;
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

  assign adc0_psclk = OPB_Clk;
  assign adc1_psclk = OPB_Clk;

  opb_reg_bank u_reg_bank (
    .OPB_Clk          (OPB_Clk),
    .arst_n           (arst_n),
    .opb_abus         (OPB_ABus),
    .opb_be           (OPB_BE),
    .opb_dbus         (OPB_DBus),
    .opb_rnw          (OPB_RNW),
    .opb_select       (OPB_select),
    .adc0_psdone      (adc0_psdone),
    .adc1_psdone      (adc1_psdone),
    .sl_dbus          (Sl_DBus),
    .sl_xfer_ack      (Sl_xferAck),
    .adc0_reset_pulse (adc0_reset_pulse),
    .adc1_reset_pulse (adc1_reset_pulse),
    .hold_resets      (hold_resets),
    .adc0_psen        (adc0_psen),
    .adc0_psincdec    (adc0_psincdec),
    .adc1_psen        (adc1_psen),
    .adc1_psincdec    (adc1_psincdec),
    .cfg0             (cfg0_if.bank),
    .cfg1             (cfg1_if.bank)
  );

  ////////////////////////////////////////////////////////////
  // per-ADC engines
  ////////////////////////////////////////////////////////////

  adc_serial_cfg u_adc0_serial (
    .OPB_Clk      (OPB_Clk),
    .arst_n       (arst_n),
    .cfg          (cfg0_if.engine),
    .ser_clk      (adc0_adc3wire_clk),
    .ser_data     (adc0_adc3wire_data),
    .ser_strobe_n (adc0_adc3wire_strobe)
  );

  adc_serial_cfg u_adc1_serial (
    .OPB_Clk      (OPB_Clk),
    .arst_n       (arst_n),
    .cfg          (cfg1_if.engine),
    .ser_clk      (adc1_adc3wire_clk),
    .ser_data     (adc1_adc3wire_data),
    .ser_strobe_n (adc1_adc3wire_strobe)
  );

  adc_dcm_reset_gen u_adc0_reset (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .reset_pulse (adc0_reset_pulse),
    .hold_resets (hold_resets),
    .adc_reset   (adc0_adc_reset),
    .dcm_reset   (adc0_dcm_reset)
  );

  adc_dcm_reset_gen u_adc1_reset (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .reset_pulse (adc1_reset_pulse),
    .hold_resets (hold_resets),
    .adc_reset   (adc1_adc_reset),
    .dcm_reset   (adc1_dcm_reset)
  );

endmodule

`default_nettype wire

//--- verif/tb_opb_adc_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_config.svh"

module tb_opb_adc_controller
  import adc_ctrl_pkg::*;
();

  localparam int FRAME_BITS = `ADC_CFG_FRAME_BITS;
  // one run from leaving idle to idle again is the CLKWAIT, DATA and FINISH periods.
  localparam int BUSY_CYCLES = (FRAME_BITS + 2) << `ADC_CFG_DIV_BITS;
  localparam int STRETCH     = `ADC_DCM_RESET_CYCLES + 1;
  localparam int TIMEOUT     = 16 * BUSY_CYCLES + 4 * STRETCH + 2048;
  localparam int ACK_LIMIT   = 16;

  logic       OPB_Clk;
  logic       arst_n;
  opb_word_t  OPB_ABus;
  opb_word_t  OPB_DBus;
  logic [0:3] OPB_BE;
  logic       OPB_RNW;
  logic       OPB_select;
  logic [1:0] psdone;
  opb_word_t  Sl_DBus;
  wire        Sl_xferAck;
  wire        Sl_errAck;
  wire        Sl_retry;
  wire        Sl_toutSup;
  wire  [1:0] ser_clk;
  wire  [1:0] ser_data;
  wire  [1:0] ser_strobe;
  wire  [1:0] adc_reset;
  wire  [1:0] dcm_reset;
  wire  [1:0] psclk;
  wire  [1:0] psen;
  wire  [1:0] psincdec;

  int         errors;
  int         test_errors_at;
  int         tests_run;
  int         tests_failed;
  string      test_name;
  cfg_addr_t  m_addr [2];
  cfg_data_t  m_data [2];
  logic       m_incdec [2];
  cfg_frame_t cap_frame [2];
  int         cap_bits [2];
  int         clk_rises [2];

  opb_adc_controller UUT (
    .OPB_Clk (OPB_Clk), .arst_n (arst_n), .OPB_ABus (OPB_ABus), .OPB_BE (OPB_BE),
    .OPB_DBus (OPB_DBus), .OPB_RNW (OPB_RNW), .OPB_select (OPB_select),
    .Sl_DBus (Sl_DBus), .Sl_xferAck (Sl_xferAck), .Sl_errAck (Sl_errAck),
    .Sl_retry (Sl_retry), .Sl_toutSup (Sl_toutSup),
    .adc0_adc3wire_clk (ser_clk[0]), .adc0_adc3wire_data (ser_data[0]),
    .adc0_adc3wire_strobe (ser_strobe[0]), .adc0_adc_reset (adc_reset[0]),
    .adc0_dcm_reset (dcm_reset[0]), .adc0_psclk (psclk[0]), .adc0_psen (psen[0]),
    .adc0_psincdec (psincdec[0]), .adc0_psdone (psdone[0]),
    .adc1_adc3wire_clk (ser_clk[1]), .adc1_adc3wire_data (ser_data[1]),
    .adc1_adc3wire_strobe (ser_strobe[1]), .adc1_adc_reset (adc_reset[1]),
    .adc1_dcm_reset (dcm_reset[1]), .adc1_psclk (psclk[1]), .adc1_psen (psen[1]),
    .adc1_psincdec (psincdec[1]), .adc1_psdone (psdone[1])
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #2 OPB_Clk = ~OPB_Clk;
  end

  initial begin
    repeat (TIMEOUT) @(posedge OPB_Clk);
    $display("Error: the run did not finish within %0d clock cycles", TIMEOUT);
    $display("Finished with errors");
    $finish;
  end

  // the ADC latches data on the rising serial clock while the strobe is low.
  for (genvar g = 0; g < 2; g++) begin : g_frame_monitor
    always @(posedge ser_clk[g]) begin
      clk_rises[g]++;
      if (!ser_strobe[g]) begin
        cap_frame[g] = {cap_frame[g][FRAME_BITS-2:0], ser_data[g]};
        cap_bits[g]++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks and test bookkeeping
  ////////////////////////////////////////////////////////////

  task automatic compare_word(string what, opb_word_t exp, opb_word_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_frame(string what, cfg_frame_t exp, cfg_frame_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(string name);
    test_name      = name;
    test_errors_at = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors_at) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, errors - test_errors_at);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model of the register map
  ////////////////////////////////////////////////////////////

  task automatic model_write(opb_reg_e r, logic [0:3] be, opb_word_t d);
    int i;
    i = (r == REG_CFG1) ? 1 : 0;
    if (r == REG_CTRL && be[1]) begin
      m_incdec[0] = d[14];
      m_incdec[1] = d[10];
    end else if (r == REG_CFG0 || r == REG_CFG1) begin
      if (be[0]) m_data[i][15:8] = d[0:7];
      if (be[1]) m_data[i][7:0] = d[8:15];
      if (be[2]) m_addr[i] = d[20:23];
    end
  endtask

  // expected read data with both engines idle and no strobe active.
  function automatic opb_word_t model_read(opb_reg_e r);
    opb_word_t w;
    int        i;
    w = '0;
    i = (r == REG_CFG1) ? 1 : 0;
    if (r == REG_CTRL) begin
      w[3]  = psdone[0];
      w[2]  = psdone[1];
      w[14] = m_incdec[0];
      w[10] = m_incdec[1];
    end else if (r != REG_RSVD) begin
      w[0:15]  = m_data[i];
      w[20:23] = m_addr[i];
      w[31]    = 1'b1;
    end
    return w;
  endfunction

  function automatic opb_word_t cfg_word(cfg_addr_t a, cfg_data_t d, logic start);
    opb_word_t w;
    w        = '0;
    w[0:15]  = d;
    w[20:23] = a;
    w[31]    = start;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus and check helpers
  ////////////////////////////////////////////////////////////

  // every task starts and returns 1 ns after a rising clock edge.
  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(posedge OPB_Clk);
      #1;
      n++;
    end while (!Sl_xferAck && n < ACK_LIMIT);
    if (!Sl_xferAck) begin
      errors++;
      $display("Error in %s: the slave never acknowledged a transfer", test_name);
    end
  endtask

  task automatic bus_write(opb_reg_e r, logic [0:3] be, opb_word_t d);
    OPB_ABus   = `ADC_CTRL_BASEADDR + 32'(r) * 4;
    OPB_BE     = be;
    OPB_DBus   = d;
    OPB_RNW    = 1'b0;
    OPB_select = 1'b1;
    wait_ack();
    OPB_select = 1'b0;
    OPB_BE     = '0;
    OPB_DBus   = '0;
  endtask

  task automatic bus_read(input opb_reg_e r, output opb_word_t d);
    OPB_ABus   = `ADC_CTRL_BASEADDR + 32'(r) * 4;
    OPB_RNW    = 1'b1;
    OPB_select = 1'b1;
    wait_ack();
    d          = Sl_DBus;
    OPB_select = 1'b0;
    OPB_RNW    = 1'b0;
  endtask

  task automatic arm_monitor(int n);
    cap_frame[n] = '0;
    cap_bits[n]  = 0;
    clk_rises[n] = 0;
  endtask

  task automatic check_frame(int n, cfg_addr_t a, cfg_data_t d);
    // the ADC expects 0x001 ahead of the register address and value.
    compare_frame($sformatf("adc%0d frame", n), {12'h001, a, d}, cap_frame[n]);
    if (cap_bits[n] != FRAME_BITS || clk_rises[n] != FRAME_BITS + 2) begin
      errors++;
      $display("Error in %s: adc%0d sent %0d bits with %0d clock pulses",
               test_name, n, cap_bits[n], clk_rises[n]);
    end
  endtask

  task automatic wait_idle(opb_reg_e r);
    opb_word_t w;
    int        n;
    n = 0;
    do begin
      bus_read(r, w);
      n++;
    end while (!w[31] && n < BUSY_CYCLES);
    if (!w[31]) begin
      errors++;
      $display("Error in %s: a serial engine never returned to idle", test_name);
    end
  endtask

  // called right after the acknowledge of a reset write.
  task automatic check_reset_stretch(logic [1:0] pulsed);
    logic [1:0] held;
    int         pulses [2];
    held      = 2'b11;
    pulses[0] = 0;
    pulses[1] = 0;
    for (int j = 1; j <= STRETCH; j++) begin
      @(posedge OPB_Clk);
      #1;
      for (int k = 0; k < 2; k++) begin
        if (adc_reset[k]) pulses[k]++;
        if (j < STRETCH && dcm_reset[k] !== pulsed[k]) held[k] = 1'b0;
      end
    end
    for (int k = 0; k < 2; k++) begin
      compare_bit($sformatf("adc%0d dcm reset during stretch", k), 1'b1, held[k]);
      compare_bit($sformatf("adc%0d dcm reset after stretch", k), 1'b0, dcm_reset[k]);
      if (pulses[k] != int'(pulsed[k])) begin
        errors++;
        $display("Error in %s: adc%0d reset pulsed %0d times", test_name, k, pulses[k]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    opb_word_t  w;
    opb_reg_e   r;
    logic [0:3] be;
    logic [1:0] en;
    logic [1:0] inc;
    logic       seen;
    cfg_addr_t  a [2];
    cfg_data_t  d [2];
    void'($urandom(66));
    arst_n     = 1'b0;
    OPB_ABus   = '0;
    OPB_DBus   = '0;
    OPB_BE     = '0;
    OPB_RNW    = 1'b0;
    OPB_select = 1'b0;
    psdone     = 2'b00;
    errors     = 0;
    tests_run  = 0;
    tests_failed = 0;
    for (int i = 0; i < 2; i++) begin
      m_addr[i]   = '0;
      m_data[i]   = '0;
      m_incdec[i] = 1'b0;
      arm_monitor(i);
    end
    repeat (10) @(posedge OPB_Clk);

    begin_test("reset_state");
    for (int k = 0; k < 2; k++) begin
      compare_bit($sformatf("adc%0d reset in reset", k), 1'b1, adc_reset[k]);
      compare_bit($sformatf("adc%0d dcm reset in reset", k), 1'b1, dcm_reset[k]);
    end
    #1 arst_n = 1'b1;
    compare_bit("xfer ack", 1'b0, Sl_xferAck);
    compare_bit("err ack", 1'b0, Sl_errAck);
    compare_bit("retry", 1'b0, Sl_retry);
    compare_bit("timeout suppress", 1'b0, Sl_toutSup);
    // the phase-shift clocks follow the bus clock, high in its first half.
    for (int k = 0; k < 2; k++) begin
      compare_bit($sformatf("adc%0d psclk high", k), 1'b1, psclk[k]);
    end
    @(negedge OPB_Clk);
    #1;
    for (int k = 0; k < 2; k++) begin
      compare_bit($sformatf("adc%0d psclk low", k), 1'b0, psclk[k]);
    end
    @(posedge OPB_Clk);
    #1;
    for (int i = 0; i < 4; i++) begin
      bus_read(opb_reg_e'(i), w);
      compare_word($sformatf("read reg %0d", i), model_read(opb_reg_e'(i)), w);
    end
    end_test();

    begin_test("register_access");
    repeat (40) begin
      r     = opb_reg_e'($urandom_range(3));
      be    = 4'($urandom);
      w     = $urandom;
      // starts and ADC resets belong to later tests.
      w[31] = 1'b0;
      if (r == REG_CTRL) be[3] = 1'b0;
      bus_write(r, be, w);
      model_write(r, be, w);
      r = opb_reg_e'($urandom_range(3));
      bus_read(r, w);
      compare_word($sformatf("read reg %0d", r), model_read(r), w);
    end
    OPB_ABus   = `ADC_CTRL_HIGHADDR + 4;
    OPB_RNW    = 1'b1;
    OPB_select = 1'b1;
    seen       = 1'b0;
    repeat (8) begin
      @(posedge OPB_Clk);
      #1;
      seen = seen | Sl_xferAck;
    end
    OPB_select = 1'b0;
    compare_bit("ack outside window", 1'b0, seen);
    end_test();

    begin_test("serial_program");
    a[0] = 4'($urandom);
    d[0] = 16'($urandom);
    arm_monitor(0);
    bus_write(REG_CFG0, 4'b1111, cfg_word(a[0], d[0], 1'b1));
    model_write(REG_CFG0, 4'b1111, cfg_word(a[0], d[0], 1'b1));
    bus_read(REG_CFG0, w);
    compare_bit("done while busy", 1'b0, w[31]);
    // the next read lands two cycles before idle, the one after it on the first idle cycle.
    repeat (BUSY_CYCLES - 3) @(posedge OPB_Clk);
    #1;
    bus_read(REG_CFG0, w);
    compare_bit("done two cycles before idle", 1'b0, w[31]);
    bus_read(REG_CFG0, w);
    compare_word("read after frame", model_read(REG_CFG0), w);
    check_frame(0, a[0], d[0]);
    end_test();

    begin_test("concurrent_engines");
    for (int i = 0; i < 2; i++) begin
      a[i] = 4'($urandom);
      d[i] = 16'($urandom);
      arm_monitor(i);
    end
    if (d[1] == d[0]) d[1] = ~d[0];
    for (int i = 0; i < 2; i++) begin
      bus_write(opb_reg_e'(i + 1), 4'b1111, cfg_word(a[i], d[i], 1'b1));
      model_write(opb_reg_e'(i + 1), 4'b1111, cfg_word(a[i], d[i], 1'b1));
    end
    for (int i = 0; i < 2; i++) begin
      bus_read(opb_reg_e'(i + 1), w);
      compare_bit($sformatf("adc%0d done while busy", i), 1'b0, w[31]);
    end
    for (int i = 0; i < 2; i++) begin
      wait_idle(opb_reg_e'(i + 1));
      check_frame(i, a[i], d[i]);
    end
    end_test();

    begin_test("adc_resets");
    compare_bit("adc0 dcm reset before first write", 1'b1, dcm_reset[0]);
    compare_bit("adc1 dcm reset before first write", 1'b1, dcm_reset[1]);
    // a value of 3 sets OPB bits 30 and 31.
    bus_write(REG_CTRL, 4'b0001, 32'h0000_0003);
    check_reset_stretch(2'b11);
    bus_write(REG_CTRL, 4'b0001, 32'h0000_0002);
    check_reset_stretch(2'b10);
    end_test();

    begin_test("phase_shift");
    repeat (16) begin
      en    = 2'($urandom);
      inc   = 2'($urandom);
      w     = '0;
      w[15] = en[0];
      w[14] = inc[0];
      w[11] = en[1];
      w[10] = inc[1];
      bus_write(REG_CTRL, 4'b0100, w);
      model_write(REG_CTRL, 4'b0100, w);
      for (int k = 0; k < 2; k++) begin
        compare_bit($sformatf("adc%0d psen pulse", k), en[k], psen[k]);
        compare_bit($sformatf("adc%0d psincdec", k), inc[k], psincdec[k]);
      end
      @(posedge OPB_Clk);
      #1;
      compare_bit("adc0 psen after one cycle", 1'b0, psen[0]);
      compare_bit("adc1 psen after one cycle", 1'b0, psen[1]);
      psdone = 2'($urandom);
      bus_read(REG_CTRL, w);
      compare_word("control readback", model_read(REG_CTRL), w);
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
source/adc_ctrl_pkg.sv
source/adc_cfg_if.sv
source/opb_reg_bank.sv
source/adc_serial_cfg.sv
source/adc_dcm_reset_gen.sv
source/opb_adc_controller.sv
verif/tb_opb_adc_controller.sv

//--- Bender.yml
package:
  name: opb_adc_controller

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/adc_ctrl_pkg.sv
      - source/adc_cfg_if.sv
      - source/opb_reg_bank.sv
      - source/adc_serial_cfg.sv
      - source/adc_dcm_reset_gen.sv
      - source/opb_adc_controller.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_opb_adc_controller.sv
